//--- build.f
src/usb_rx_pkg.sv
src/usb_byte_rx.sv
src/usb_pkt_decode.sv
src/usb_rx_fifo_out.sv
src/usb_rx_top.sv
dv/tb_usb_rx.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_usb_rx -f build.f \
  && ./obj_dir/Vtb_usb_rx | tee /dev/stderr | grep -Fx '>>> PASS' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- dv/tb_usb_rx.sv
`default_nettype none

module tb_usb_rx;

  timeunit 1ns;
  timeprecision 1ns;

  import usb_rx_pkg::*;

  localparam usb_addr_t DEV_ADDR   = 7'h2a;
  localparam usb_addr_t OTHER_ADDR = 7'h15;
  // Longest run is about 5000 cycles, mostly the slow-consumer packets
  localparam int MAX_CYCLES = 20000;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  in_req_i;
  usb_byte_t             in_data_i;
  logic                  in_last_i;
  logic                  in_ack_o;
  usb_addr_t             usb_address_i;
  logic                  sof_o;
  logic                  crc_err_o;
  logic                  trn_start_o;
  usb_kind_t             trn_type_o;
  usb_addr_t             trn_address_o;
  usb_endp_t             trn_endpoint_o;
  logic                  hsk_recv_o;
  usb_kind_t             hsk_type_o;
  logic                  out_req_o;
  usb_byte_t             out_data_o;
  logic                  out_end_o;
  logic                  out_ack_i;

  logic [31:0] stim_rng = 32'hae21fcbd;
  // Consumer draws from its own stream
  logic [31:0] ack_rng  = 32'hae21fcbd;
  usb_byte_t   pkt[$];
  logic [8:0]  exp_q[$];
  logic        slow = 1'b0;
  int          errors = 0;
  int          tests = 0;
  int          test_errors;
  int          cycles = 0;
  int          sof_cnt = 0;
  int          err_cnt = 0;
  int          trn_cnt = 0;
  int          hsk_cnt = 0;
  int          base_sof;
  int          base_err;
  int          base_trn;
  int          base_hsk;
  usb_kind_t   exp_kind;
  usb_addr_t   exp_addr;
  usb_endp_t   exp_endp;
  usb_kind_t   exp_hsk;

  usb_rx_top #(
    .FIFO_DEPTH (8)
  ) UUT (
    .clock          (clock),
    .reset          (reset),
    .in_req_i       (in_req_i),
    .in_data_i      (in_data_i),
    .in_last_i      (in_last_i),
    .in_ack_o       (in_ack_o),
    .usb_address_i  (usb_address_i),
    .sof_o          (sof_o),
    .crc_err_o      (crc_err_o),
    .trn_start_o    (trn_start_o),
    .trn_type_o     (trn_type_o),
    .trn_address_o  (trn_address_o),
    .trn_endpoint_o (trn_endpoint_o),
    .hsk_recv_o     (hsk_recv_o),
    .hsk_type_o     (hsk_type_o),
    .out_req_o      (out_req_o),
    .out_data_o     (out_data_o),
    .out_end_o      (out_end_o),
    .out_ack_i      (out_ack_i)
  );

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  function automatic usb_byte_t pid_byte(input logic [3:0] code);
    return {~code, code};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pulses(input string name, input int exp, input int act);
    assert (exp == act) else begin
      if (act < exp) begin
        $display("Time %0t: %s pulse missing, saw %0d of %0d", $time, name, act, exp);
      end else begin
        $display("Time %0t: %s pulsed %0d times, %0d expected", $time, name, act, exp);
      end
      errors++;
    end
  endtask

  task automatic rule_broken(input string what);
    $display("Time %0t: handshake rule broken, %s", $time, what);
    errors++;
  endtask

  // Input link, DUT is the receiver
  assert property (@(posedge clock) disable iff (reset) $rose(in_ack_o) |-> $past(in_req_i))
    else rule_broken("in_ack_o rose while in_req_i was low");
  assert property (@(posedge clock) disable iff (reset) $fell(in_ack_o) |-> !$past(in_req_i))
    else rule_broken("in_ack_o fell while in_req_i was high");
  // Output link, DUT is the sender
  assert property (@(posedge clock) disable iff (reset) $fell(out_req_o) |-> $past(out_ack_i))
    else rule_broken("out_req_o fell before out_ack_i was raised");
  assert property (@(posedge clock) disable iff (reset) $rose(out_req_o) |-> !$past(out_ack_i))
    else rule_broken("out_req_o rose while out_ack_i was still high");

  // Strobe monitor
  always @(posedge clock) begin
    if (!reset) begin
      if (sof_o) begin
        sof_cnt++;
      end
      if (crc_err_o) begin
        err_cnt++;
      end
      if (trn_start_o) begin
        trn_cnt++;
        check_value("trn_type_o", 32'(exp_kind), 32'(trn_type_o));
        check_value("trn_address_o", 32'(exp_addr), 32'(trn_address_o));
        check_value("trn_endpoint_o", 32'(exp_endp), 32'(trn_endpoint_o));
      end
      if (hsk_recv_o) begin
        hsk_cnt++;
        check_value("hsk_type_o", 32'(exp_hsk), 32'(hsk_type_o));
      end
    end
  end

  // Endpoint consumer with a random acknowledge delay
  always @(negedge clock) begin : consumer
    int wait_cycles;
    if (!reset && out_req_o && !out_ack_i) begin
      ack_rng     = xorshift32(ack_rng);
      wait_cycles = int'(ack_rng[2:0]) + (slow ? 8 : 0);
      repeat (wait_cycles) @(negedge clock);
      if (exp_q.size() == 0) begin
        $display("Time %0t: output entry %0h arrived with none expected",
                 $time, {out_end_o, out_data_o});
        errors++;
      end else begin
        check_value("out_end_o", 32'(exp_q[0][8]), 32'(out_end_o));
        check_value("out_data_o", 32'(exp_q[0][7:0]), 32'(out_data_o));
        void'(exp_q.pop_front());
      end
      out_ack_i = 1'b1;
      do @(negedge clock); while (out_req_o);
      out_ack_i = 1'b0;
    end
  end

  // Drives the bytes in pkt over the four-phase input link
  task automatic send_packet();
    for (int i = 0; i < pkt.size(); i++) begin
      while (in_ack_o) @(negedge clock);
      in_data_i = pkt[i];
      in_last_i = (i == pkt.size() - 1);
      in_req_i  = 1'b1;
      do @(negedge clock); while (!in_ack_o);
      in_req_i = 1'b0;
      @(negedge clock);
    end
    while (in_ack_o) @(negedge clock);
    // Strobes land two clocks after the last byte
    repeat (3) @(negedge clock);
  endtask

  task automatic send_token(input logic [3:0] code, input logic [10:0] bits, input logic flip);
    usb_byte_t last;
    int        k;
    last = {usb_crc5(bits), bits[10:8]};
    if (flip) begin
      k       = 3 + int'(next_rand() % 32'd5);
      last[k] = ~last[k];
    end
    pkt.delete();
    pkt.push_back(pid_byte(code));
    pkt.push_back(bits[7:0]);
    pkt.push_back(last);
    send_packet();
  endtask

  task automatic send_dev_token(input usb_kind_t kind);
    exp_kind = kind;
    exp_addr = DEV_ADDR;
    exp_endp = usb_endp_t'(next_rand());
    send_token({kind, PID_GRP_TOKEN}, {exp_endp, DEV_ADDR}, 1'b0);
  endtask

  task automatic send_data(input usb_kind_t kind, input int n, input logic flip,
                           input logic delivered);
    usb_crc16_t crc;
    usb_crc16_t fin;
    usb_byte_t  b;
    int         k;
    crc = '1;
    pkt.delete();
    pkt.push_back(pid_byte({kind, PID_GRP_DATA}));
    for (int i = 0; i < n; i++) begin
      b   = usb_byte_t'(next_rand());
      crc = usb_crc16(b, crc);
      pkt.push_back(b);
      if (delivered) begin
        exp_q.push_back({1'b0, b});
      end
    end
    // Remainder goes out inverted and bit reversed, low byte first
    for (int i = 0; i < 16; i++) begin
      fin[i] = ~crc[15-i];
    end
    if (flip) begin
      k      = int'(next_rand() % 32'd16);
      fin[k] = ~fin[k];
    end
    pkt.push_back(fin[7:0]);
    pkt.push_back(fin[15:8]);
    if (delivered) begin
      exp_q.push_back({1'b1, 7'b0, !flip});
    end
    send_packet();
  endtask

  task automatic take_snapshot();
    base_sof = sof_cnt;
    base_err = err_cnt;
    base_trn = trn_cnt;
    base_hsk = hsk_cnt;
  endtask

  task automatic expect_pulses(input int sof, input int err, input int trn, input int hsk);
    check_pulses("sof_o", sof, sof_cnt - base_sof);
    check_pulses("crc_err_o", err, err_cnt - base_err);
    check_pulses("trn_start_o", trn, trn_cnt - base_trn);
    check_pulses("hsk_recv_o", hsk, hsk_cnt - base_hsk);
    take_snapshot();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clock);
  endtask

  task automatic begin_test();
    take_snapshot();
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    end
  endtask

  task automatic test_sof();
    logic [10:0] frame;
    begin_test();
    frame = 11'(next_rand());
    send_token(PID_SOF, frame, 1'b0);
    expect_pulses(1, 0, 0, 0);
    send_token(PID_SOF, frame + 11'd1, 1'b1);
    expect_pulses(0, 1, 0, 0);
    end_test("sof");
  endtask

  task automatic test_tokens();
    begin_test();
    // Kind 01 is SOF, the other three are OUT, IN and SETUP
    for (int k = 0; k < 4; k++) begin
      if (k != 1) begin
        send_dev_token(usb_kind_t'(k));
        expect_pulses(0, 0, 1, 0);
      end
    end
    send_token({2'b00, PID_GRP_TOKEN}, {4'h3, OTHER_ADDR}, 1'b0);
    expect_pulses(0, 0, 0, 0);
    send_token({2'b10, PID_GRP_TOKEN}, {4'h5, DEV_ADDR}, 1'b1);
    expect_pulses(0, 1, 0, 0);
    end_test("tokens");
  endtask

  task automatic test_data(input logic flip);
    begin_test();
    for (int i = 0; i < 4; i++) begin
      send_dev_token(2'b00);
      send_data(i[0] ? 2'b10 : 2'b00, 1 + int'(next_rand() % 32'd16), flip, 1'b1);
      expect_pulses(0, flip ? 1 : 0, 1, 0);
      wait_drain();
    end
    end_test(flip ? "data bad crc16" : "data good crc16");
  endtask

  task automatic test_handshake();
    logic [31:0] r;
    usb_byte_t   b;
    begin_test();
    for (int k = 0; k < 4; k++) begin
      send_dev_token(2'b00);
      expect_pulses(0, 0, 1, 0);
      exp_hsk = usb_kind_t'(k);
      pkt.delete();
      pkt.push_back(pid_byte({exp_hsk, PID_GRP_HSK}));
      send_packet();
      expect_pulses(0, 0, 0, 1);
    end
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      b = r[7:0];
      if (b[3:0] == ~b[7:4]) begin
        b[0] = ~b[0];
      end
      pkt.delete();
      pkt.push_back(b);
      if (i[0]) begin
        pkt.push_back(r[15:8]);
        pkt.push_back(r[23:16]);
      end
      send_packet();
    end
    expect_pulses(0, 0, 0, 0);
    end_test("handshake and bad pid");
  endtask

  task automatic test_backpressure();
    begin_test();
    slow = 1'b1;
    send_dev_token(2'b00);
    for (int i = 0; i < 10; i++) begin
      send_data(i[0] ? 2'b10 : 2'b00, 16, 1'b0, 1'b1);
    end
    wait_drain();
    slow = 1'b0;
    expect_pulses(0, 0, 1, 0);
    send_token({2'b00, PID_GRP_TOKEN}, {4'h1, OTHER_ADDR}, 1'b0);
    send_data(2'b00, 8, 1'b0, 1'b0);
    repeat (20) @(negedge clock);
    assert (!out_req_o) else begin
      $display("Time %0t: output entry left over after a packet to another address", $time);
      errors++;
    end
    expect_pulses(0, 0, 0, 0);
    end_test("back-pressure");
  endtask

  initial begin
    reset         = 1'b1;
    in_req_i      = 1'b0;
    in_data_i     = '0;
    in_last_i     = 1'b0;
    usb_address_i = DEV_ADDR;
    out_ack_i     = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    test_sof();
    test_tokens();
    test_data(1'b0);
    test_data(1'b1);
    test_handshake();
    test_backpressure();
    repeat (20) @(negedge clock);
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/usb_rx_top.sv
`default_nettype none

module usb_rx_top #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  in_req_i,
  input  usb_rx_pkg::usb_byte_t in_data_i,
  input  logic                  in_last_i,
  output logic                  in_ack_o,
  input  usb_rx_pkg::usb_addr_t usb_address_i,
  output logic                  sof_o,
  output logic                  crc_err_o,
  output logic                  trn_start_o,
  output usb_rx_pkg::usb_kind_t trn_type_o,
  output usb_rx_pkg::usb_addr_t trn_address_o,
  output usb_rx_pkg::usb_endp_t trn_endpoint_o,
  output logic                  hsk_recv_o,
  output usb_rx_pkg::usb_kind_t hsk_type_o,
  output logic                  out_req_o,
  output usb_rx_pkg::usb_byte_t out_data_o,
  output logic                  out_end_o,
  input  logic                  out_ack_i
);

  import usb_rx_pkg::*;

  logic      byte_valid;
  usb_byte_t byte_data;
  logic      byte_last;
  logic      fifo_space;
  logic      pay_valid;
  usb_byte_t pay_data;
  logic      pay_end;
  logic      pay_crc_ok;

  usb_byte_rx u_byte_rx (
    .clock        (clock),
    .reset        (reset),
    .in_req_i     (in_req_i),
    .in_data_i    (in_data_i),
    .in_last_i    (in_last_i),
    .in_ack_o     (in_ack_o),
    .space_i      (fifo_space),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data),
    .byte_last_o  (byte_last)
  );

  usb_pkt_decode u_pkt_decode (
    .clock          (clock),
    .reset          (reset),
    .byte_valid_i   (byte_valid),
    .byte_data_i    (byte_data),
    .byte_last_i    (byte_last),
    .usb_address_i  (usb_address_i),
    .sof_o          (sof_o),
    .crc_err_o      (crc_err_o),
    .trn_start_o    (trn_start_o),
    .trn_type_o     (trn_type_o),
    .trn_address_o  (trn_address_o),
    .trn_endpoint_o (trn_endpoint_o),
    .hsk_recv_o     (hsk_recv_o),
    .hsk_type_o     (hsk_type_o),
    .pay_valid_o    (pay_valid),
    .pay_data_o     (pay_data),
    .pay_end_o      (pay_end),
    .pay_crc_ok_o   (pay_crc_ok)
  );

  usb_rx_fifo_out #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo_out (
    .clock        (clock),
    .reset        (reset),
    .pay_valid_i  (pay_valid),
    .pay_data_i   (pay_data),
    .pay_end_i    (pay_end),
    .pay_crc_ok_i (pay_crc_ok),
    .space_o      (fifo_space),
    .out_req_o    (out_req_o),
    .out_data_o   (out_data_o),
    .out_end_o    (out_end_o),
    .out_ack_i    (out_ack_i)
  );

endmodule

`default_nettype wire

//--- src/usb_rx_fifo_out.sv
`default_nettype none

module usb_rx_fifo_out #(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pay_valid_i,
  input  usb_rx_pkg::usb_byte_t pay_data_i,
  input  logic                  pay_end_i,
  input  logic                  pay_crc_ok_i,
  output logic                  space_o,
  output logic                  out_req_o,
  output usb_rx_pkg::usb_byte_t out_data_o,
  output logic                  out_end_o,
  input  logic                  out_ack_i
);

  import usb_rx_pkg::*;

  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W      = PTR_W + 1;
  localparam int unsigned FILL_LIMIT = FIFO_DEPTH - FIFO_RESERVE;

  typedef enum logic [1:0] {
    SND_IDLE,
    SND_REQ,
    SND_WAIT_REL
  } snd_state_t;

  snd_state_t       snd_state;
  logic [8:0]       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic [8:0]       wr_entry;

  // Entry bit 8 marks end of packet, bit 0 then holds CRC status
  assign push     = pay_valid_i || pay_end_i;
  assign wr_entry = pay_end_i ? {1'b1, 7'b0, pay_crc_ok_i} : {1'b0, pay_data_i};
  assign pop      = snd_state == SND_REQ && out_ack_i;

  assign space_o    = count <= CNT_W'(FILL_LIMIT);
  assign out_req_o  = snd_state == SND_REQ;
  assign out_data_o = mem[rd_ptr][7:0];
  assign out_end_o  = mem[rd_ptr][8];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Four-phase sender, pops when ack rises
  always_ff @(posedge clock) begin
    if (reset) begin
      snd_state <= SND_IDLE;
    end else begin
      case (snd_state)
        SND_IDLE: begin
          if (count != '0) begin
            snd_state <= SND_REQ;
          end
        end
        SND_REQ: begin
          if (out_ack_i) begin
            snd_state <= SND_WAIT_REL;
          end
        end
        SND_WAIT_REL: begin
          if (!out_ack_i) begin
            snd_state <= SND_IDLE;
          end
        end
        default: snd_state <= SND_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/usb_pkt_decode.sv
`default_nettype none

module usb_pkt_decode (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  byte_valid_i,
  input  usb_rx_pkg::usb_byte_t byte_data_i,
  input  logic                  byte_last_i,
  input  usb_rx_pkg::usb_addr_t usb_address_i,
  output logic                  sof_o,
  output logic                  crc_err_o,
  output logic                  trn_start_o,
  output usb_rx_pkg::usb_kind_t trn_type_o,
  output usb_rx_pkg::usb_addr_t trn_address_o,
  output usb_rx_pkg::usb_endp_t trn_endpoint_o,
  output logic                  hsk_recv_o,
  output usb_rx_pkg::usb_kind_t hsk_type_o,
  output logic                  pay_valid_o,
  output usb_rx_pkg::usb_byte_t pay_data_o,
  output logic                  pay_end_o,
  output logic                  pay_crc_ok_o
);

  import usb_rx_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SOF,
    ST_SOF_CHECK,
    ST_TOKEN,
    ST_TOKEN_CHECK,
    ST_DATA,
    ST_DATA_CHECK
  } dec_state_t;

  dec_state_t  state;
  logic [3:0]  pid_code;
  logic        pid_ok;
  logic        pkt_start;
  logic [10:0] tok_bits;
  usb_crc5_t   tok_crc5;
  logic        crc5_ok;
  usb_byte_t   buf0;
  usb_byte_t   buf1;
  logic        held0;
  logic        held1;
  usb_crc16_t  crc16;
  usb_crc16_t  crc16_fin;
  logic        crc16_ok;
  logic        addr_match;
  usb_kind_t   kind_q;

  // A PID is only looked for on the first byte of a packet
  assign pid_code   = byte_data_i[3:0];
  assign pid_ok     = pkt_start && (pid_code == ~byte_data_i[7:4]);
  assign crc5_ok    = tok_crc5 == usb_crc5(tok_bits);
  assign addr_match = tok_bits[6:0] == usb_address_i;

  // Remainder is sent inverted and bit reversed, low byte first
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      crc16_fin[i] = ~crc16[15-i];
    end
  end
  assign crc16_ok = {buf0, buf1} == crc16_fin;

  assign trn_type_o     = kind_q;
  assign hsk_type_o     = kind_q;
  assign trn_address_o  = tok_bits[6:0];
  assign trn_endpoint_o = tok_bits[10:7];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (byte_valid_i && pid_ok && !byte_last_i) begin
            if (pid_code == PID_SOF) begin
              state <= ST_SOF;
            end else if (pid_code[1:0] == PID_GRP_TOKEN) begin
              state <= ST_TOKEN;
            end else if (pid_code[1:0] == PID_GRP_DATA) begin
              state <= ST_DATA;
            end
          end
        end
        ST_SOF: begin
          if (byte_valid_i && byte_last_i) begin
            state <= ST_SOF_CHECK;
          end
        end
        ST_TOKEN: begin
          if (byte_valid_i && byte_last_i) begin
            state <= ST_TOKEN_CHECK;
          end
        end
        ST_DATA: begin
          if (byte_valid_i && byte_last_i) begin
            state <= ST_DATA_CHECK;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Packet boundary tracking and the two-byte holding pipe
  always_ff @(posedge clock) begin
    if (reset) begin
      pkt_start <= 1'b1;
      held0     <= 1'b0;
      held1     <= 1'b0;
    end else begin
      if (byte_valid_i) begin
        pkt_start <= byte_last_i;
      end
      if (state == ST_IDLE) begin
        held0 <= 1'b0;
        held1 <= 1'b0;
      end else if (byte_valid_i) begin
        held0 <= 1'b1;
        held1 <= held0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (byte_valid_i) begin
      buf0       <= byte_data_i;
      buf1       <= buf0;
      pay_data_o <= buf1;
    end
    // Token fields, shared by SOF and token packets
    if ((state == ST_SOF || state == ST_TOKEN) && byte_valid_i) begin
      if (!held0) begin
        tok_bits[7:0] <= byte_data_i;
      end else if (!held1) begin
        tok_bits[10:8] <= byte_data_i[2:0];
        tok_crc5       <= byte_data_i[7:3];
      end
    end
    // CRC16 covers only bytes that have left the pipe
    if (state == ST_IDLE) begin
      crc16 <= '1;
    end else if (byte_valid_i && held1) begin
      crc16 <= usb_crc16(buf1, crc16);
    end
    if (state == ST_IDLE && byte_valid_i && pid_ok) begin
      kind_q <= byte_data_i[3:2];
    end
    if (state == ST_DATA_CHECK) begin
      pay_crc_ok_o <= crc16_ok;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sof_o       <= 1'b0;
      crc_err_o   <= 1'b0;
      trn_start_o <= 1'b0;
      hsk_recv_o  <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_end_o   <= 1'b0;
    end else begin
      sof_o       <= state == ST_SOF_CHECK && crc5_ok;
      trn_start_o <= state == ST_TOKEN_CHECK && crc5_ok && addr_match;
      pay_end_o   <= state == ST_DATA_CHECK && addr_match;
      pay_valid_o <= state == ST_DATA && byte_valid_i && held1 && addr_match;
      hsk_recv_o  <= state == ST_IDLE && byte_valid_i && pid_ok &&
                     pid_code[1:0] == PID_GRP_HSK && addr_match;
      case (state)
        ST_SOF_CHECK, ST_TOKEN_CHECK: crc_err_o <= !crc5_ok;
        ST_DATA_CHECK: crc_err_o <= !crc16_ok;
        default: crc_err_o <= 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/usb_byte_rx.sv
`default_nettype none

module usb_byte_rx (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_req_i,
  input  usb_rx_pkg::usb_byte_t in_data_i,
  input  logic                 in_last_i,
  output logic                 in_ack_o,
  input  logic                 space_i,
  output logic                 byte_valid_o,
  output usb_rx_pkg::usb_byte_t byte_data_o,
  output logic                 byte_last_o
);

  typedef enum logic {
    RX_WAIT_REQ,
    RX_WAIT_REL
  } rx_state_t;

  rx_state_t state;

  // Handshake and strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= RX_WAIT_REQ;
      in_ack_o     <= 1'b0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      case (state)
        RX_WAIT_REQ: begin
          // Hold off the source while the FIFO is near full
          if (in_req_i && space_i) begin
            byte_valid_o <= 1'b1;
            state        <= RX_WAIT_REL;
          end
        end
        RX_WAIT_REL: begin
          if (!in_ack_o) begin
            in_ack_o <= 1'b1;
          end else if (!in_req_i) begin
            in_ack_o <= 1'b0;
            state    <= RX_WAIT_REQ;
          end
        end
        default: state <= RX_WAIT_REQ;
      endcase
    end
  end

  // Byte sampled once per request, aligned with the strobe
  always_ff @(posedge clock) begin
    if (state == RX_WAIT_REQ && in_req_i && space_i) begin
      byte_data_o <= in_data_i;
      byte_last_o <= in_last_i;
    end
  end

endmodule

`default_nettype wire

//--- src/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

  typedef logic [7:0]  usb_byte_t;
  typedef logic [6:0]  usb_addr_t;
  typedef logic [3:0]  usb_endp_t;
  typedef logic [1:0]  usb_kind_t;
  typedef logic [4:0]  usb_crc5_t;
  typedef logic [15:0] usb_crc16_t;

  // Low two PID bits select the packet group
  localparam logic [1:0] PID_GRP_TOKEN = 2'b01;
  localparam logic [1:0] PID_GRP_DATA  = 2'b11;
  localparam logic [1:0] PID_GRP_HSK   = 2'b10;
  localparam logic [3:0] PID_SOF       = 4'b0101;

  // Free entries needed before another input byte is taken
  localparam int unsigned FIFO_RESERVE = 4;

  // CRC5 over the eleven token bits, returned as the field sits in the byte
  function automatic usb_crc5_t usb_crc5(input logic [10:0] bits);
    usb_crc5_t crc;
    usb_crc5_t field;
    logic fb;
    crc = '1;
    for (int i = 0; i < 11; i++) begin
      fb = bits[i] ^ crc[4];
      crc = {crc[3:0], 1'b0};
      if (fb) begin
        crc = crc ^ 5'b00101;
      end
    end
    // Inverted remainder goes out MSB first
    for (int i = 0; i < 5; i++) begin
      field[i] = ~crc[4-i];
    end
    return field;
  endfunction

  // One byte of CRC16 update, LSB first
  function automatic usb_crc16_t usb_crc16(input usb_byte_t data, input usb_crc16_t crc);
    usb_crc16_t next;
    logic fb;
    next = crc;
    for (int i = 0; i < 8; i++) begin
      fb = data[i] ^ next[15];
      next = {next[14:0], 1'b0};
      if (fb) begin
        next = next ^ 16'h8005;
      end
    end
    return next;
  endfunction

endpackage

`default_nettype wire
